// ==== logic/chan_defines.svh ====
`ifndef CHAN_DEFINES_SVH
`define CHAN_DEFINES_SVH

////////////////////////////////////////////////////////////////////////////
// channel datapath sizes

// width of one channel word
`define CHAN_DATA_W      16

// number of fifo entries
`define CHAN_FIFO_DEPTH  8

// occupancy width, must hold 0 up to the full depth
`define CHAN_LEVEL_W     4

////////////////////////////////////////////////////////////////////////////
// configuration register map

`define CHAN_REG_CTRL    2'd0
`define CHAN_REG_WMARK   2'd1
`define CHAN_REG_COUNT   2'd2

`endif

// ==== logic/chan_pkg.sv ====
`include "chan_defines.svh"

package chan_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // datapath vectors

  // one word on the input, fifo or output channel
  typedef logic [`CHAN_DATA_W-1:0] chan_data_t;

  // fifo occupancy, also used for the watermark
  typedef logic [`CHAN_LEVEL_W-1:0] chan_level_t;

  ////////////////////////////////////////////////////////////////////////////
  // configuration port vectors

  typedef logic [1:0] cfg_addr_t;
  typedef logic [15:0] cfg_word_t;

  // output stage holds at most one word
  typedef enum logic {
    stage_empty,
    stage_full
  } out_state_t;

endpackage

// ==== logic/chan_fifo.sv ====
`timescale 1ns/1ns

`include "chan_defines.svh"

module chan_fifo import chan_pkg::*; (
  input  logic        clk,
  input  logic        reset,

  // write side, valid/ack channel
  input  logic        in_v,
  input  chan_data_t  in_d,
  output logic        in_a,

  // read side, oldest word shown first
  output logic        fifo_v,
  output chan_data_t  fifo_d,
  input  logic        fifo_a,

  output chan_level_t fifo_level
);

  localparam int PTR_W = $clog2(`CHAN_FIFO_DEPTH);
  localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(`CHAN_FIFO_DEPTH - 1);
  localparam chan_level_t FULL_LEVEL = chan_level_t'(`CHAN_FIFO_DEPTH);

  chan_data_t mem [`CHAN_FIFO_DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  chan_level_t      count;

  logic wr_en;
  logic rd_en;

  // pointer step with wrap at the last entry
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    if (ptr == LAST_PTR) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // handshakes

  // ack only looks at the registered count, never at in_v
  assign in_a   = (count != FULL_LEVEL);
  assign fifo_v = (count != '0);
  assign fifo_d = mem[rd_ptr];

  assign wr_en = in_v && in_a;
  assign rd_en = fifo_v && fifo_a;

  assign fifo_level = count;

  ////////////////////////////////////////////////////////////////////////////
  // storage

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= in_d;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (rd_en) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
    end
  end

  // write and read together leave the count alone
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      count <= '0;
    end else begin
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // checks

  // write pointer runs ahead of the read pointer by exactly the occupancy
  a_ptr_level: assert property (
    @(posedge clk) disable iff (reset)
    (wr_ptr - rd_ptr) == PTR_W'(count)
  );

  // the stage must never take a word from an empty buffer, and a lone
  // read drops the level by one on the next cycle
  a_no_read_empty: assert property (
    @(posedge clk) disable iff (reset)
    (fifo_a && !wr_en && count != '0) |=> (count == $past(count) - 1'b1)
  );

endmodule

// ==== logic/chan_out_stage.sv ====
`timescale 1ns/1ns

module chan_out_stage import chan_pkg::*; (
  input  logic       clk,
  input  logic       reset,

  // from the fifo read side
  input  logic       fifo_v,
  input  chan_data_t fifo_d,
  output logic       fifo_a,

  input  logic       pause,

  // output channel, driven from registers
  output logic       out_v,
  output chan_data_t out_d,
  input  logic       out_a
);

  out_state_t state;
  out_state_t state_nxt;
  chan_data_t data_q;

  logic load;

  // take a new word when empty, or when the held word leaves this cycle
  assign fifo_a = !pause && ((state == stage_empty) || out_a);
  assign load   = fifo_v && fifo_a;

  assign out_v = (state == stage_full);
  assign out_d = data_q;

  always_comb begin
    state_nxt = state;
    case (state)
      stage_empty: begin
        if (load) begin
          state_nxt = stage_full;
        end
      end
      stage_full: begin
        // drain and refill on the same edge keeps the stage full
        if (out_a && !load) begin
          state_nxt = stage_empty;
        end
      end
      default: state_nxt = stage_empty;
    endcase
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state <= stage_empty;
    end else begin
      state <= state_nxt;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      data_q <= fifo_d;
    end
  end

  // a stalled output word holds until the sink takes it
  a_out_stable: assert property (
    @(posedge clk) disable iff (reset)
    (out_v && !out_a) |=> (out_v && $stable(out_d))
  );

endmodule

// ==== logic/chan_ctrl_regs.sv ====
`timescale 1ns/1ns

`include "chan_defines.svh"

module chan_ctrl_regs import chan_pkg::*; (
  input  logic        clk,
  input  logic        reset,

  // configuration port
  input  logic        cfg_wr,
  input  cfg_addr_t   cfg_addr,
  input  cfg_word_t   cfg_wdata,
  output cfg_word_t   cfg_rdata,

  // input channel, watched only
  input  logic        in_v,
  input  logic        in_a,

  input  chan_level_t fifo_level,

  output logic        pause,
  output logic        almost_full
);

  localparam chan_level_t DEPTH_LEVEL = chan_level_t'(`CHAN_FIFO_DEPTH);

  logic        pause_q;
  chan_level_t wmark_q;
  cfg_word_t   count_q;

  logic in_xfer;
  logic wr_ctrl;
  logic wr_wmark;
  logic wr_count;

  assign in_xfer  = in_v && in_a;
  assign wr_ctrl  = cfg_wr && (cfg_addr == `CHAN_REG_CTRL);
  assign wr_wmark = cfg_wr && (cfg_addr == `CHAN_REG_WMARK);
  assign wr_count = cfg_wr && (cfg_addr == `CHAN_REG_COUNT);

  ////////////////////////////////////////////////////////////////////////////
  // registers

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      pause_q <= 1'b0;
      wmark_q <= DEPTH_LEVEL;
    end else begin
      if (wr_ctrl) begin
        pause_q <= cfg_wdata[0];
      end
      if (wr_wmark) begin
        wmark_q <= cfg_wdata[`CHAN_LEVEL_W-1:0];
      end
    end
  end

  // clear wins over the count, but a transfer in the same cycle still counts
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      count_q <= '0;
    end else if (wr_count) begin
      count_q <= in_xfer ? cfg_word_t'(1) : '0;
    end else if (in_xfer) begin
      count_q <= count_q + 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // read decode and flags

  always_comb begin
    case (cfg_addr)
      `CHAN_REG_CTRL:  cfg_rdata = {15'b0, pause_q};
      `CHAN_REG_WMARK: cfg_rdata = {{(16 - `CHAN_LEVEL_W){1'b0}}, wmark_q};
      `CHAN_REG_COUNT: cfg_rdata = count_q;
      default:         cfg_rdata = '0;
    endcase
  end

  assign pause       = pause_q;
  assign almost_full = (fifo_level >= wmark_q);

  // software must not program a watermark above the buffer depth
  a_wmark_range: assert property (
    @(posedge clk) disable iff (reset)
    wr_wmark |-> (cfg_wdata <= cfg_word_t'(`CHAN_FIFO_DEPTH))
  );

endmodule

// ==== logic/chan_buffer_top.sv ====
`timescale 1ns/1ns

module chan_buffer_top import chan_pkg::*; (
  input  logic        clk,
  input  logic        reset,

  // input channel
  input  logic        in_v,
  input  chan_data_t  in_d,
  output logic        in_a,

  // output channel
  output logic        out_v,
  output chan_data_t  out_d,
  input  logic        out_a,

  // configuration port
  input  logic        cfg_wr,
  input  cfg_addr_t   cfg_addr,
  input  cfg_word_t   cfg_wdata,
  output cfg_word_t   cfg_rdata,

  output logic        almost_full,
  output chan_level_t fifo_level
);

  // fifo to stage link
  logic       fifo_v;
  chan_data_t fifo_d;
  logic       fifo_a;

  logic pause;

  chan_fifo i_chan_fifo (
    .clk        (clk),
    .reset      (reset),
    .in_v       (in_v),
    .in_d       (in_d),
    .in_a       (in_a),
    .fifo_v     (fifo_v),
    .fifo_d     (fifo_d),
    .fifo_a     (fifo_a),
    .fifo_level (fifo_level)
  );

  chan_out_stage i_chan_out_stage (
    .clk    (clk),
    .reset  (reset),
    .fifo_v (fifo_v),
    .fifo_d (fifo_d),
    .fifo_a (fifo_a),
    .pause  (pause),
    .out_v  (out_v),
    .out_d  (out_d),
    .out_a  (out_a)
  );

  // register block counts accepted input words beside the datapath
  chan_ctrl_regs i_chan_ctrl_regs (
    .clk         (clk),
    .reset       (reset),
    .cfg_wr      (cfg_wr),
    .cfg_addr    (cfg_addr),
    .cfg_wdata   (cfg_wdata),
    .cfg_rdata   (cfg_rdata),
    .in_v        (in_v),
    .in_a        (in_a),
    .fifo_level  (fifo_level),
    .pause       (pause),
    .almost_full (almost_full)
  );

endmodule

// ==== testbench/tb_lfsr.svh ====
// galois lfsr for testbench random bits, included inside each module
// that needs them so every module keeps its own state
// polynomial x^32 + x^22 + x^2 + x + 1, shifting right
localparam logic [31:0] LFSR_SEED = 32'h9ba3c3f4;
localparam logic [31:0] LFSR_TAPS = 32'h80200003;

logic [31:0] lfsr_state = LFSR_SEED;

// one step for every bit taken, first bit lands in the lsb
function automatic logic [31:0] rand_bits(input int n);
  logic [31:0] value;
  value = '0;
  for (int i = 0; i < n; i++) begin
    value[i] = lfsr_state[0];
    if (lfsr_state[0]) begin
      lfsr_state = (lfsr_state >> 1) ^ LFSR_TAPS;
    end else begin
      lfsr_state = lfsr_state >> 1;
    end
  end
  return value;
endfunction

// ==== testbench/chan_traffic.sv ====
`timescale 1ns/1ns

`include "chan_defines.svh"

////////////////////////////////////////////////////////////////////////////
// random source for the input channel

module chan_rand_src import chan_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  logic       enable,
  // total number of words to send since reset
  input  int         limit,
  input  logic       in_a,
  output logic       in_v,
  output chan_data_t in_d
);

  `include "tb_lfsr.svh"

  int   sent;
  logic taken;

  initial begin
    in_v = 1'b0;
    in_d = '0;
  end

  // transfers are seen on the rising edge
  always @(posedge clk or posedge reset) begin
    if (reset) begin
      sent  <= 0;
      taken <= 1'b0;
    end else begin
      taken <= in_v && in_a;
      if (in_v && in_a) begin
        sent <= sent + 1;
      end
    end
  end

  // an offered word stays put until taken, then maybe a gap
  always @(negedge clk) begin
    if (reset) begin
      in_v <= 1'b0;
    end else if (!in_v || taken) begin
      if (enable && (sent < limit) && (rand_bits(2) != 0)) begin
        in_v <= 1'b1;
        in_d <= chan_data_t'(rand_bits(`CHAN_DATA_W));
      end else begin
        in_v <= 1'b0;
      end
    end
  end

endmodule

////////////////////////////////////////////////////////////////////////////
// random acknowledging sink for the output channel

module chan_rand_sink (
  input  logic clk,
  input  logic reset,
  input  logic enable,
  input  logic out_v,
  output logic out_a
);

  `include "tb_lfsr.svh"

  initial begin
    out_a = 1'b0;
  end

  // ack about three cycles in four while a word is shown
  always @(negedge clk) begin
    if (reset || !enable) begin
      out_a <= 1'b0;
    end else if (out_v) begin
      out_a <= (rand_bits(2) != 0);
    end else begin
      out_a <= 1'b0;
    end
  end

endmodule

// ==== testbench/chan_buffer_tb.sv ====
`timescale 1ns/1ns

`include "chan_defines.svh"

module chan_buffer_tb
  import chan_pkg::*;
();

  localparam int DEPTH = `CHAN_FIFO_DEPTH;

  logic        clk;
  logic        reset;
  logic        in_v;
  chan_data_t  in_d;
  logic        in_a;
  logic        out_v;
  chan_data_t  out_d;
  logic        out_a;
  logic        cfg_wr;
  cfg_addr_t   cfg_addr;
  cfg_word_t   cfg_wdata;
  cfg_word_t   cfg_rdata;
  logic        almost_full;
  chan_level_t fifo_level;

  logic src_enable;
  int   src_limit;
  logic sink_enable;

  // words accepted but not yet delivered, oldest first
  chan_data_t model_q[$];
  int accepted;
  int delivered;
  int count_model;
  int wmark_model;
  int checks;
  int errors;

  // buffer occupancy and output stage as the model tracks them
  int   level_model;
  logic stage_model;
  logic stage_load;
  logic pause_model;

  chan_buffer_top i_chan_buffer_top (
    .clk         (clk),
    .reset       (reset),
    .in_v        (in_v),
    .in_d        (in_d),
    .in_a        (in_a),
    .out_v       (out_v),
    .out_d       (out_d),
    .out_a       (out_a),
    .cfg_wr      (cfg_wr),
    .cfg_addr    (cfg_addr),
    .cfg_wdata   (cfg_wdata),
    .cfg_rdata   (cfg_rdata),
    .almost_full (almost_full),
    .fifo_level  (fifo_level)
  );

  chan_rand_src i_src (
    .clk    (clk),
    .reset  (reset),
    .enable (src_enable),
    .limit  (src_limit),
    .in_a   (in_a),
    .in_v   (in_v),
    .in_d   (in_d)
  );

  chan_rand_sink i_sink (
    .clk    (clk),
    .reset  (reset),
    .enable (sink_enable),
    .out_v  (out_v),
    .out_a  (out_a)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    checks++;
    if (got !== expected) begin
      errors++;
      $display("Error: %s is %h, expected %h", name, got, expected);
    end
  endtask

  task automatic write_reg(input cfg_addr_t addr, input cfg_word_t data);
    @(negedge clk);
    cfg_wr    <= 1'b1;
    cfg_addr  <= addr;
    cfg_wdata <= data;
    @(negedge clk);
    cfg_wr <= 1'b0;
    case (addr)
      `CHAN_REG_CTRL:  pause_model = data[0];
      `CHAN_REG_WMARK: wmark_model = data;
      `CHAN_REG_COUNT: count_model = 0;
      default: ;
    endcase
  endtask

  // read data is combinational, taken once the address has settled
  task automatic read_reg(input cfg_addr_t addr, output cfg_word_t data);
    @(negedge clk);
    cfg_addr <= addr;
    @(negedge clk);
    data = cfg_rdata;
  endtask

  task automatic wait_drained(input int target, input int max_cycles, input string what);
    int cycles;
    cycles = 0;
    while ((accepted < target || model_q.size() != 0) && cycles < max_cycles) begin
      @(negedge clk);
      cycles++;
    end
    if (accepted < target || model_q.size() != 0) begin
      errors++;
      $display("timed out after %0d cycles waiting for %s", max_cycles, what);
    end
  endtask

  task automatic wait_stalled(input int stall_cycles, input int max_cycles);
    int cycles;
    int low_run;
    cycles  = 0;
    low_run = 0;
    while (low_run < stall_cycles && cycles < max_cycles) begin
      @(negedge clk);
      cycles++;
      low_run = in_a ? 0 : low_run + 1;
    end
    if (low_run < stall_cycles) begin
      errors++;
      $display("in_a never stayed low for %0d cycles within %0d cycles",
               stall_cycles, max_cycles);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // reference model, updated on every rising edge

  always @(posedge clk) begin
    if (!reset) begin
      // state before this edge
      check_value("fifo_level", fifo_level, level_model);
      check_value("out_v", out_v, stage_model);
      check_value("in_a", in_a, level_model != DEPTH);
      check_value("almost_full", almost_full, level_model >= wmark_model);
      if (in_v && in_a) begin
        model_q.push_back(in_d);
        accepted++;
        count_model++;
      end
      if (out_v && out_a) begin
        if (model_q.size() == 0) begin
          errors++;
          $display("output transfer while no accepted word is outstanding");
        end else begin
          check_value("out_d", out_d, model_q.pop_front());
        end
        delivered++;
      end
      // stage refills when empty or draining, never while paused
      stage_load = (level_model != 0) && !pause_model && (!stage_model || out_a);
      level_model = level_model + ((in_v && level_model != DEPTH) ? 1 : 0)
                    - (stage_load ? 1 : 0);
      if (stage_load) begin
        stage_model = 1'b1;
      end else if (out_a) begin
        stage_model = 1'b0;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // scenario sequence

  initial begin
    cfg_word_t rdata;
    int a0;
    int d0;
    checks      = 0;
    errors      = 0;
    accepted    = 0;
    delivered   = 0;
    count_model = 0;
    wmark_model = DEPTH;
    level_model = 0;
    stage_model = 1'b0;
    stage_load  = 1'b0;
    pause_model = 1'b0;
    reset       = 1'b1;
    cfg_wr      = 1'b0;
    cfg_addr    = '0;
    cfg_wdata   = '0;
    src_enable  = 1'b0;
    src_limit   = 0;
    sink_enable = 1'b0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    reset <= 1'b0;

    // state right after reset
    @(negedge clk);
    check_value("out_v", out_v, 0);
    check_value("in_a", in_a, 1);
    check_value("almost_full", almost_full, 0);
    read_reg(`CHAN_REG_CTRL, rdata);
    check_value("cfg_rdata", rdata, 0);
    read_reg(`CHAN_REG_WMARK, rdata);
    check_value("cfg_rdata", rdata, DEPTH);
    read_reg(`CHAN_REG_COUNT, rdata);
    check_value("cfg_rdata", rdata, 0);

    // ordering under random gaps and random acks
    src_enable  <= 1'b1;
    sink_enable <= 1'b1;
    src_limit   <= 200;
    wait_drained(200, 4000, "200 words to pass through");
    check_value("delivered words", delivered, 200);
    read_reg(`CHAN_REG_COUNT, rdata);
    check_value("cfg_rdata", rdata, count_model % 65536);
    write_reg(`CHAN_REG_COUNT, 16'h0000);
    read_reg(`CHAN_REG_COUNT, rdata);
    check_value("cfg_rdata", rdata, 0);

    // back-pressure, buffer plus stage fill up
    sink_enable <= 1'b0;
    repeat (2) @(negedge clk);
    a0 = accepted;
    d0 = delivered;
    src_limit <= a0 + 20;
    wait_stalled(20, 200);
    check_value("input transfers", accepted - a0, DEPTH + 1);
    check_value("output transfers", delivered - d0, 0);
    check_value("fifo_level", fifo_level, DEPTH);

    // pause lets at most the staged word out
    write_reg(`CHAN_REG_CTRL, 16'h0001);
    sink_enable <= 1'b1;
    d0 = delivered;
    repeat (30) @(negedge clk);
    if (delivered - d0 > 1) begin
      errors++;
      $display("%0d output transfers while paused, at most 1 expected", delivered - d0);
    end
    write_reg(`CHAN_REG_CTRL, 16'h0000);
    wait_drained(a0 + 20, 1000, "words held back by pause");

    // watermark, almost_full is checked by the model on every edge
    write_reg(`CHAN_REG_WMARK, 16'h0003);
    read_reg(`CHAN_REG_WMARK, rdata);
    check_value("cfg_rdata", rdata, 3);
    a0 = accepted;
    src_limit <= a0 + 150;
    wait_drained(a0 + 150, 3000, "watermark run to finish");

    // count since the last clear, then clear with the source idle
    read_reg(`CHAN_REG_COUNT, rdata);
    check_value("cfg_rdata", rdata, count_model % 65536);
    write_reg(`CHAN_REG_COUNT, 16'h0000);
    read_reg(`CHAN_REG_COUNT, rdata);
    check_value("cfg_rdata", rdata, 0);

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// ==== project.f ====
+incdir+logic
+incdir+testbench
logic/chan_pkg.sv
logic/chan_fifo.sv
logic/chan_out_stage.sv
logic/chan_ctrl_regs.sv
logic/chan_buffer_top.sv
testbench/chan_traffic.sv
testbench/chan_buffer_tb.sv
